// File: src/sxt_macros.svh
// ============================================================
// Sample extraction final stage sizes
// Coefficient geometry, ciphertext layout, burst split
// and queue depths shared by the RTL and the packages
// ============================================================

`ifndef SXT_MACROS_SVH
`define SXT_MACROS_SVH

// Coefficient geometry
`define SXT_COEF_W           8
`define SXT_HALF_COEF_NB     2
`define SXT_REGF_COEF_NB     2
`define SXT_CHUNK_NB         2

// Ciphertext layout, 3 mask beats and 1 body beat
`define SXT_CT_WORD_NB       7

// Burst split, 3 + 3 + 1 words
`define SXT_WORD_THRESHOLD   3
`define SXT_CMD_NB           3
`define SXT_LAST_CMD_WORD_NB 1

// Queue depths, data buffer at least one burst
`define SXT_DATA_DEPTH       4
`define SXT_RCP_DEPTH        3
`define SXT_ACK_DEPTH        2

// Command field widths
`define SXT_PID_W            4
`define SXT_RID_W            6
`define SXT_WORD_ADD_W       3

`endif

// File: src/sxt_data_pkg.sv
// ============================================================
// Data path types of the final stage
// Coefficients, input halves, merged words, regfile words
// ============================================================

`include "sxt_macros.svh"

package sxt_data_pkg;

  // One coefficient
  typedef logic [`SXT_COEF_W-1:0] coef_t;

  // Input half, coefficient 0 in the low bits
  typedef coef_t [`SXT_HALF_COEF_NB-1:0] half_word_t;

  // Both halves after the permutation
  typedef coef_t [2*`SXT_HALF_COEF_NB-1:0] merged_word_t;

  // Register file word
  typedef coef_t [`SXT_REGF_COEF_NB-1:0] regf_word_t;

endpackage

// File: src/sxt_ctrl_pkg.sv
// ============================================================
// Control types of the final stage
// Input command, reception command, acknowledge entry
// and register file write request
// ============================================================

`include "sxt_macros.svh"

package sxt_ctrl_pkg;

  typedef logic [`SXT_PID_W-1:0]      pid_t;
  typedef logic [`SXT_RID_W-1:0]      rid_t;
  typedef logic [`SXT_WORD_ADD_W-1:0] word_add_t;

  // Command riding with the main half
  typedef struct packed {
    pid_t pid;
    rid_t dst_rid;
    logic is_body;
    logic is_last;
  } in_cmd_t;

  // One per ciphertext, taken on its first beat
  typedef struct packed {
    pid_t pid;
    rid_t dst_rid;
    logic is_last;
  } rcp_cmd_t;

  // Waits for the write acknowledges
  typedef struct packed {
    pid_t pid;
    logic is_last;
  } ack_cmd_t;

  // Register file write burst
  typedef struct packed {
    rid_t                                   reg_id;
    word_add_t                              start_word;
    logic [$clog2(`SXT_WORD_THRESHOLD)-1:0] word_nb_m1;
  } regf_req_t;

endpackage

// File: src/sxt_fifo.sv
// ============================================================
// Register FIFO
// Circular buffer with valid/ready on both sides
// Output valid comes from the registered occupancy
// ============================================================

`timescale 1ns/1ps

module sxt_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             s_rst_n,

  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,

  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Full FIFO still takes a push when a pop frees a slot
  assign in_ready  = (count != CNT_W'(DEPTH)) | out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      // Occupancy holds when both happen
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

// File: src/sxt_perm_fork.sv
// ============================================================
// Input join, permutation and command fork
// Joins subs and main halves, swaps them on request
// and splits the reception command off on the first
// beat of each ciphertext
// ============================================================

`timescale 1ns/1ps

module sxt_perm_fork (
  input  logic                      clk,
  input  logic                      s_rst_n,

  input  sxt_data_pkg::half_word_t  subs_data,
  input  logic                      subs_valid,
  output logic                      subs_ready,

  input  sxt_data_pkg::half_word_t  main_data,
  input  logic                      main_swap,
  input  sxt_ctrl_pkg::in_cmd_t     main_cmd,
  input  logic                      main_valid,
  output logic                      main_ready,

  output sxt_data_pkg::merged_word_t out_data,
  output logic                      out_is_body,
  output logic                      out_valid,
  input  logic                      out_ready,

  output sxt_ctrl_pkg::rcp_cmd_t    rcp_cmd,
  output logic                      rcp_valid,
  input  logic                      rcp_ready
);

  import sxt_data_pkg::*;

  half_word_t lo_half;
  half_word_t hi_half;
  logic       in_valid;
  logic       join_ready;
  logic       sos;

  // ==========================================================
  // Join
  // ==========================================================
  // Both halves move together
  assign in_valid   = subs_valid & main_valid;
  assign subs_ready = join_ready & main_valid;
  assign main_ready = join_ready & subs_valid;

  // Subs low, main high unless swapped
  assign lo_half     = main_swap ? main_data : subs_data;
  assign hi_half     = main_swap ? subs_data : main_data;
  assign out_data    = {hi_half, lo_half};
  assign out_is_body = main_cmd.is_body;

  // ==========================================================
  // Fork
  // ==========================================================
  // Start of ciphertext: after reset and after each body beat
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sos <= 1'b1;
    end else if (in_valid && join_ready) begin
      sos <= main_cmd.is_body;
    end
  end

  // First beat needs both the data path and the reception queue
  assign join_ready = out_ready & (rcp_ready | ~sos);
  assign out_valid  = in_valid & (rcp_ready | ~sos);
  assign rcp_valid  = in_valid & out_ready & sos;

  assign rcp_cmd.pid     = main_cmd.pid;
  assign rcp_cmd.dst_rid = main_cmd.dst_rid;
  assign rcp_cmd.is_last = main_cmd.is_last;

endmodule

// File: src/sxt_word_splitter.sv
// ============================================================
// Merged word splitter
// Shifts a merged word out one register file word at a
// time, low chunk first; a body beat gives chunk 0 only
// ============================================================

`timescale 1ns/1ps

`include "sxt_macros.svh"

module sxt_word_splitter (
  input  logic                       clk,
  input  logic                       s_rst_n,

  input  sxt_data_pkg::merged_word_t in_data,
  input  logic                       in_is_body,
  input  logic                       in_valid,
  output logic                       in_ready,

  output sxt_data_pkg::regf_word_t   out_data,
  output logic                       out_valid,
  input  logic                       out_ready
);

  import sxt_data_pkg::*;

  localparam int CNT_W = (`SXT_CHUNK_NB > 1) ? $clog2(`SXT_CHUNK_NB) : 1;

  merged_word_t sr_data;
  logic         sr_is_body;
  logic         sr_avail;
  logic [CNT_W-1:0] sr_cnt;
  logic         sr_last;
  logic         in_xfer;
  logic         out_xfer;

  assign in_xfer  = in_valid & in_ready;
  assign out_xfer = sr_avail & out_ready;

  // Body beat ends after its first chunk
  assign sr_last = (sr_cnt == CNT_W'(`SXT_CHUNK_NB - 1)) | sr_is_body;

  // Reload in the cycle the last chunk leaves
  assign in_ready  = ~sr_avail | (sr_last & out_ready);
  assign out_valid = sr_avail;
  assign out_data  = sr_data[`SXT_REGF_COEF_NB-1:0];

  // Control
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sr_avail <= 1'b0;
      sr_cnt   <= '0;
    end else begin
      if (in_xfer)                 sr_avail <= 1'b1;
      else if (out_xfer && sr_last) sr_avail <= 1'b0;
      if (out_xfer) sr_cnt <= sr_last ? '0 : sr_cnt + 1'b1;
    end
  end

  // Shift register
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      sr_data    <= in_data;
      sr_is_body <= in_is_body;
    end else if (out_xfer) begin
      sr_data <= sr_data >> $bits(regf_word_t);
    end
  end

endmodule

// File: src/sxt_regf_req.sv
// ============================================================
// Register file write request generator
// Queues reception commands, counts buffered words and
// issues 3, 3 and 1 word bursts per ciphertext
// ============================================================

`timescale 1ns/1ps

`include "sxt_macros.svh"

module sxt_regf_req (
  input  logic                   clk,
  input  logic                   s_rst_n,

  input  sxt_ctrl_pkg::rcp_cmd_t rcp_cmd,
  input  logic                   rcp_valid,
  output logic                   rcp_ready,

  input  logic                   word_push,

  output sxt_ctrl_pkg::regf_req_t req,
  output logic                   req_valid,
  input  logic                   req_ready,

  output sxt_ctrl_pkg::ack_cmd_t ack_cmd,
  output logic                   ack_push
);

  import sxt_ctrl_pkg::*;

  localparam int WCNT_W  = $clog2(`SXT_CT_WORD_NB + `SXT_DATA_DEPTH + 1);
  localparam int CMD_W   = (`SXT_CMD_NB > 1) ? $clog2(`SXT_CMD_NB) : 1;
  localparam int NB_M1_W = $clog2(`SXT_WORD_THRESHOLD);

  rcp_cmd_t         rcp_q;
  logic             rcp_q_valid;
  logic             rcp_q_ready;

  logic [WCNT_W-1:0] word_cnt;
  logic [WCNT_W-1:0] burst_nb;
  logic [CMD_W-1:0]  cmd_cnt;
  word_add_t         word_add;
  logic              last_cmd;

  regf_req_t         r0_req;
  logic              r0_valid;
  logic              r0_ready;
  logic              send;

  // ==========================================================
  // Reception queue
  // ==========================================================
  sxt_fifo #(
    .WIDTH ($bits(rcp_cmd_t)),
    .DEPTH (`SXT_RCP_DEPTH)
  ) rcp_fifo (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .in_data   (rcp_cmd),
    .in_valid  (rcp_valid),
    .in_ready  (rcp_ready),
    .out_data  (rcp_q),
    .out_valid (rcp_q_valid),
    .out_ready (rcp_q_ready)
  );

  // ==========================================================
  // Burst sequencing
  // ==========================================================
  assign last_cmd = (cmd_cnt == CMD_W'(`SXT_CMD_NB - 1));
  assign burst_nb = last_cmd ? WCNT_W'(`SXT_LAST_CMD_WORD_NB) : WCNT_W'(`SXT_WORD_THRESHOLD);

  // Enough words in the buffer for the current burst
  assign r0_valid = rcp_q_valid & (word_cnt >= burst_nb);
  assign send     = r0_valid & r0_ready;

  assign r0_req.reg_id     = rcp_q.dst_rid;
  assign r0_req.start_word = word_add;
  assign r0_req.word_nb_m1 = last_cmd ? NB_M1_W'(`SXT_LAST_CMD_WORD_NB - 1)
                                      : NB_M1_W'(`SXT_WORD_THRESHOLD - 1);

  // Command done after its last burst, hand it to the ack side
  assign rcp_q_ready   = send & last_cmd;
  assign ack_push      = rcp_q_ready;
  assign ack_cmd.pid     = rcp_q.pid;
  assign ack_cmd.is_last = rcp_q.is_last;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      word_cnt <= '0;
      cmd_cnt  <= '0;
      word_add <= '0;
    end else begin
      // Up per buffered word, down by a burst when sent
      word_cnt <= word_cnt + WCNT_W'(word_push) - (send ? burst_nb : '0);
      if (send) begin
        cmd_cnt  <= last_cmd ? '0 : cmd_cnt + 1'b1;
        word_add <= last_cmd ? '0 : word_add + word_add_t'(`SXT_WORD_THRESHOLD);
      end
    end
  end

  // ==========================================================
  // Request output register
  // ==========================================================
  assign r0_ready = ~req_valid | req_ready;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      req_valid <= 1'b0;
    end else if (r0_ready) begin
      req_valid <= r0_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (send) req <= r0_req;
  end

endmodule

// File: src/sxt_ack_track.sv
// ============================================================
// Write acknowledge tracker
// Counts register file acknowledges per ciphertext and
// pulses done with the pid once a last one completes
// ============================================================

`timescale 1ns/1ps

`include "sxt_macros.svh"

module sxt_ack_track (
  input  logic                   clk,
  input  logic                   s_rst_n,

  input  sxt_ctrl_pkg::ack_cmd_t ack_cmd,
  input  logic                   ack_push,

  input  logic                   regf_ack,

  output logic                   done,
  output sxt_ctrl_pkg::pid_t     done_pid
);

  import sxt_ctrl_pkg::*;

  localparam int CMD_W = (`SXT_CMD_NB > 1) ? $clog2(`SXT_CMD_NB) : 1;

  ack_cmd_t         ack_q;
  logic             ack_q_valid;
  logic             ack_q_ready;
  logic             ack_r;
  logic [CMD_W-1:0] ack_cnt;
  logic             last_ack;

  // Sized to cover the acknowledge latency, push never blocks
  sxt_fifo #(
    .WIDTH ($bits(ack_cmd_t)),
    .DEPTH (`SXT_ACK_DEPTH)
  ) ack_fifo (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .in_data   (ack_cmd),
    .in_valid  (ack_push),
    .in_ready  (),
    .out_data  (ack_q),
    .out_valid (ack_q_valid),
    .out_ready (ack_q_ready)
  );

  // One ack per burst, the last burst closes the entry
  assign last_ack    = (ack_cnt == CMD_W'(`SXT_CMD_NB - 1));
  assign ack_q_ready = ack_r & last_ack;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ack_r   <= 1'b0;
      ack_cnt <= '0;
      done    <= 1'b0;
    end else begin
      ack_r <= regf_ack;
      if (ack_r) ack_cnt <= last_ack ? '0 : ack_cnt + 1'b1;
      done <= ack_q_ready & ack_q_valid & ack_q.is_last;
    end
  end

  // Pid held until the next completed entry
  always_ff @(posedge clk) begin
    if (ack_q_ready) done_pid <= ack_q.pid;
  end

endmodule

// File: src/sxt_final.sv
// ============================================================
// Sample extraction final stage
// Joins subs and main halves, splits them into register
// file words, buffers them and issues write bursts,
// then reports each completed ciphertext with its pid
// ============================================================

`timescale 1ns/1ps

`include "sxt_macros.svh"

module sxt_final (
  input  logic                      clk,
  input  logic                      s_rst_n,

  // Input halves
  input  sxt_data_pkg::half_word_t  subs_data,
  input  logic                      subs_valid,
  output logic                      subs_ready,

  input  sxt_data_pkg::half_word_t  main_data,
  input  logic                      main_swap,
  input  sxt_ctrl_pkg::in_cmd_t     main_cmd,
  input  logic                      main_valid,
  output logic                      main_ready,

  // Register file write
  output sxt_ctrl_pkg::regf_req_t   wr_req,
  output logic                      wr_req_valid,
  input  logic                      wr_req_ready,

  output sxt_data_pkg::regf_word_t  wr_data,
  output logic                      wr_data_valid,
  input  logic                      wr_data_ready,

  input  logic                      regf_ack,

  // Ciphertext done
  output logic                      done,
  output sxt_ctrl_pkg::pid_t        done_pid
);

  import sxt_data_pkg::*;
  import sxt_ctrl_pkg::*;

  merged_word_t x0_data;
  logic         x0_is_body;
  logic         x0_valid;
  logic         x0_ready;

  regf_word_t   x1_data;
  logic         x1_valid;
  logic         x1_ready;

  rcp_cmd_t     rcp_cmd;
  logic         rcp_valid;
  logic         rcp_ready;

  ack_cmd_t     ack_cmd;
  logic         ack_push;
  logic         word_push;

  // ==========================================================
  // Data path
  // ==========================================================
  sxt_perm_fork u_perm_fork (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .subs_data   (subs_data),
    .subs_valid  (subs_valid),
    .subs_ready  (subs_ready),
    .main_data   (main_data),
    .main_swap   (main_swap),
    .main_cmd    (main_cmd),
    .main_valid  (main_valid),
    .main_ready  (main_ready),
    .out_data    (x0_data),
    .out_is_body (x0_is_body),
    .out_valid   (x0_valid),
    .out_ready   (x0_ready),
    .rcp_cmd     (rcp_cmd),
    .rcp_valid   (rcp_valid),
    .rcp_ready   (rcp_ready)
  );

  sxt_word_splitter u_splitter (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data    (x0_data),
    .in_is_body (x0_is_body),
    .in_valid   (x0_valid),
    .in_ready   (x0_ready),
    .out_data   (x1_data),
    .out_valid  (x1_valid),
    .out_ready  (x1_ready)
  );

  // Buffer holds at least one full burst
  sxt_fifo #(
    .WIDTH ($bits(regf_word_t)),
    .DEPTH (`SXT_DATA_DEPTH)
  ) u_data_fifo (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .in_data   (x1_data),
    .in_valid  (x1_valid),
    .in_ready  (x1_ready),
    .out_data  (wr_data),
    .out_valid (wr_data_valid),
    .out_ready (wr_data_ready)
  );

  // Word count tap at the buffer input
  assign word_push = x1_valid & x1_ready;

  // ==========================================================
  // Requests and acknowledges
  // ==========================================================
  sxt_regf_req u_regf_req (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .rcp_cmd   (rcp_cmd),
    .rcp_valid (rcp_valid),
    .rcp_ready (rcp_ready),
    .word_push (word_push),
    .req       (wr_req),
    .req_valid (wr_req_valid),
    .req_ready (wr_req_ready),
    .ack_cmd   (ack_cmd),
    .ack_push  (ack_push)
  );

  sxt_ack_track u_ack_track (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .ack_cmd  (ack_cmd),
    .ack_push (ack_push),
    .regf_ack (regf_ack),
    .done     (done),
    .done_pid (done_pid)
  );

endmodule

// File: bench/sxt_final_tb.sv
// ============================================================
// Testbench for the sample extraction final stage
// Table of ciphertexts driven beat by beat, register file
// model with random stalls, data, request and done checks
// ============================================================

`timescale 1ns/1ps

`include "sxt_macros.svh"

module sxt_final_tb;

  import sxt_data_pkg::*;
  import sxt_ctrl_pkg::*;

  localparam int CT_NB       = 6;
  localparam int BEAT_NB     = 4;
  localparam int CT_WORD_NB  = `SXT_CT_WORD_NB;
  localparam int BURST_NB    = `SXT_CMD_NB;
  localparam int NB_M1_W     = $clog2(`SXT_WORD_THRESHOLD);
  localparam int TOTAL_WORDS = CT_NB * CT_WORD_NB;
  localparam int TOTAL_REQS  = CT_NB * BURST_NB;
  localparam int RST_CYCLES  = 8;
  localparam int CYCLE_LIMIT = CT_NB * 60;
  // Bit i set when ciphertext i is flagged last
  localparam logic [CT_NB-1:0] LAST_MASK = 6'b101101;

  // One ciphertext with its stimulus and the words it must produce
  typedef struct packed {
    pid_t                        pid;
    rid_t                        dst_rid;
    logic                        is_last;
    logic [BEAT_NB-1:0]          swap;
    half_word_t [BEAT_NB-1:0]    subs_half;
    half_word_t [BEAT_NB-1:0]    main_half;
    regf_word_t [CT_WORD_NB-1:0] exp_word;
  } ct_entry_t;

  logic        clk = 1'b0;
  logic        s_rst_n;
  half_word_t  subs_data;
  logic        subs_valid;
  logic        subs_ready;
  half_word_t  main_data;
  logic        main_swap;
  in_cmd_t     main_cmd;
  logic        main_valid;
  logic        main_ready;
  regf_req_t   wr_req;
  logic        wr_req_valid;
  logic        wr_req_ready;
  regf_word_t  wr_data;
  logic        wr_data_valid;
  logic        wr_data_ready;
  logic        regf_ack;
  logic        done;
  pid_t        done_pid;

  ct_entry_t   ct_tab [CT_NB];
  integer      seed = 74;
  int          word_idx = 0;
  int          req_idx = 0;
  int          ack_seen = 0;
  int          done_seen = 0;
  int          cycle_cnt = 0;
  // Expected done delayed by two cycles
  logic [1:0]  exp_done_pipe = '0;
  pid_t        exp_pid_d0 = '0;
  pid_t        exp_pid_d1 = '0;

  always #20 clk = ~clk;

  sxt_final UUT (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .subs_data     (subs_data),
    .subs_valid    (subs_valid),
    .subs_ready    (subs_ready),
    .main_data     (main_data),
    .main_swap     (main_swap),
    .main_cmd      (main_cmd),
    .main_valid    (main_valid),
    .main_ready    (main_ready),
    .wr_req        (wr_req),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready),
    .wr_data       (wr_data),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .regf_ack      (regf_ack),
    .done          (done),
    .done_pid      (done_pid)
  );

  // ==========================================================
  // Failure reporting
  // ==========================================================
  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "Run stopped at the first failing check");
  endtask

  task automatic report_mismatch(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_on_failure();
  endtask

  // ==========================================================
  // Stimulus table
  // ==========================================================
  task automatic build_table();
    half_word_t lo;
    half_word_t hi;
    int         w;
    for (int i = 0; i < CT_NB; i++) begin
      ct_tab[i].pid     = pid_t'($random(seed));
      ct_tab[i].dst_rid = rid_t'($random(seed));
      ct_tab[i].is_last = LAST_MASK[i];
      ct_tab[i].swap    = BEAT_NB'($random(seed));
      w = 0;
      for (int b = 0; b < BEAT_NB; b++) begin
        ct_tab[i].subs_half[b] = half_word_t'($random(seed));
        ct_tab[i].main_half[b] = half_word_t'($random(seed));
        // Subs half low unless the beat is swapped
        lo = ct_tab[i].swap[b] ? ct_tab[i].main_half[b] : ct_tab[i].subs_half[b];
        hi = ct_tab[i].swap[b] ? ct_tab[i].subs_half[b] : ct_tab[i].main_half[b];
        ct_tab[i].exp_word[w] = lo;
        w++;
        // Body beat keeps its low chunk only
        if (b != BEAT_NB - 1) begin
          ct_tab[i].exp_word[w] = hi;
          w++;
        end
      end
    end
  endtask

  function automatic int count_last();
    int n;
    n = 0;
    for (int i = 0; i < CT_NB; i++) begin
      if (ct_tab[i].is_last) n++;
    end
    return n;
  endfunction

  // Hold one beat until both halves are taken
  task automatic send_beat(input ct_entry_t e, input int b);
    in_cmd_t cmd;
    cmd.pid     = e.pid;
    cmd.dst_rid = e.dst_rid;
    cmd.is_body = (b == BEAT_NB - 1);
    cmd.is_last = e.is_last;
    subs_data  <= e.subs_half[b];
    main_data  <= e.main_half[b];
    main_swap  <= e.swap[b];
    main_cmd   <= cmd;
    subs_valid <= 1'b1;
    main_valid <= 1'b1;
    @(negedge clk);
    while (!(subs_ready && main_ready)) @(negedge clk);
    @(posedge clk);
  endtask

  // ==========================================================
  // Checkers
  // ==========================================================
  task automatic check_idle(input string phase);
    assert (wr_req_valid === 1'b0 && wr_data_valid === 1'b0 && done === 1'b0)
      else report_mismatch($sformatf("outputs not low %s", phase));
  endtask

  task automatic check_request(output int len);
    regf_req_t exp_req;
    int        ct;
    int        k;
    assert (req_idx < TOTAL_REQS) else report_mismatch("request beyond the last ciphertext");
    ct  = req_idx / BURST_NB;
    k   = req_idx % BURST_NB;
    len = (k == BURST_NB - 1) ? `SXT_LAST_CMD_WORD_NB : `SXT_WORD_THRESHOLD;
    exp_req.reg_id     = ct_tab[ct].dst_rid;
    exp_req.start_word = word_add_t'(k * `SXT_WORD_THRESHOLD);
    exp_req.word_nb_m1 = NB_M1_W'(len - 1);
    assert (wr_req === exp_req)
      else report_mismatch($sformatf(
        "request %0d expected rid %0d start %0d nb_m1 %0d, got rid %0d start %0d nb_m1 %0d",
        req_idx, exp_req.reg_id, exp_req.start_word, exp_req.word_nb_m1,
        wr_req.reg_id, wr_req.start_word, wr_req.word_nb_m1));
    req_idx++;
  endtask

  task automatic check_word();
    regf_word_t exp;
    assert (word_idx < TOTAL_WORDS) else report_mismatch("word beyond the last ciphertext");
    exp = ct_tab[word_idx / CT_WORD_NB].exp_word[word_idx % CT_WORD_NB];
    assert (wr_data === exp)
      else report_mismatch($sformatf("word %0d expected %h got %h", word_idx, exp, wr_data));
    word_idx++;
  endtask

  // Done due two cycles after the third ack of a last ciphertext
  task automatic check_done();
    logic new_done;
    pid_t new_pid;
    int   ct;
    assert (done === exp_done_pipe[1])
      else report_mismatch($sformatf("done expected %0b got %0b", exp_done_pipe[1], done));
    if (exp_done_pipe[1]) begin
      assert (done_pid === exp_pid_d1)
        else report_mismatch($sformatf("done_pid expected %0d got %0d", exp_pid_d1, done_pid));
    end
    // Pulses seen on the DUT output
    if (done === 1'b1) done_seen++;
    new_done = 1'b0;
    new_pid  = '0;
    ct       = ack_seen / BURST_NB;
    if (regf_ack === 1'b1) begin
      if (ct < CT_NB && ack_seen % BURST_NB == BURST_NB - 1 && ct_tab[ct].is_last) begin
        new_done = 1'b1;
        new_pid  = ct_tab[ct].pid;
      end
      ack_seen++;
    end
    exp_done_pipe = {exp_done_pipe[0], new_done};
    exp_pid_d1    = exp_pid_d0;
    exp_pid_d0    = new_pid;
  endtask

  // ==========================================================
  // Register file model
  // ==========================================================
  // Samples on the falling edge and drives on the rising edge
  initial begin : regf_model
    int         burst_q [$];
    int         len;
    logic [2:0] ack_dly;
    logic       burst_end;
    wr_req_ready  = 1'b0;
    wr_data_ready = 1'b0;
    regf_ack      = 1'b0;
    ack_dly       = '0;
    forever begin
      @(negedge clk);
      burst_end = 1'b0;
      if (s_rst_n) begin
        check_done();
        if (wr_req_valid && wr_req_ready) begin
          check_request(len);
          burst_q.push_back(len);
        end
        // Data only taken for an accepted burst
        if (wr_data_valid && wr_data_ready) begin
          check_word();
          burst_q[0] = burst_q[0] - 1;
          if (burst_q[0] == 0) begin
            void'(burst_q.pop_front());
            burst_end = 1'b1;
          end
        end
      end
      @(posedge clk);
      // Ack three cycles after the last word of a burst
      ack_dly = {ack_dly[1:0], burst_end};
      regf_ack <= ack_dly[2];
      wr_req_ready  <= s_rst_n && (($random(seed) & 1) != 0);
      wr_data_ready <= s_rst_n && (burst_q.size() > 0) && (($random(seed) & 3) != 0);
    end
  end

  // ==========================================================
  // Timeout
  // ==========================================================
  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    stop_on_failure();
  end

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin : stimulus
    s_rst_n    = 1'b0;
    subs_data  = '0;
    subs_valid = 1'b0;
    main_data  = '0;
    main_swap  = 1'b0;
    main_cmd   = '0;
    main_valid = 1'b0;
    build_table();

    repeat (RST_CYCLES) begin
      @(negedge clk);
      check_idle("during reset");
    end
    @(posedge clk);
    s_rst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_idle("right after reset");
    end
    @(posedge clk);

    for (int ct = 0; ct < CT_NB; ct++) begin
      for (int b = 0; b < BEAT_NB; b++) begin
        send_beat(ct_tab[ct], b);
      end
    end
    subs_valid <= 1'b0;
    main_valid <= 1'b0;

    // Let done drain once all words, requests and acks are seen
    wait (word_idx == TOTAL_WORDS && req_idx == TOTAL_REQS && ack_seen == TOTAL_REQS);
    repeat (4) @(negedge clk);
    assert (done_seen == count_last()) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_mismatch($sformatf("done pulses expected %0d got %0d",
                                count_last(), done_seen));
    end
  end

endmodule

// File: compile.f
+incdir+src
src/sxt_data_pkg.sv
src/sxt_ctrl_pkg.sv
src/sxt_fifo.sv
src/sxt_perm_fork.sv
src/sxt_word_splitter.sv
src/sxt_regf_req.sv
src/sxt_ack_track.sv
src/sxt_final.sv
bench/sxt_final_tb.sv

// File: Bender.yml
package:
  name: sxt_final

sources:
  - include_dirs:
      - src
    files:
      - src/sxt_data_pkg.sv
      - src/sxt_ctrl_pkg.sv
      - src/sxt_fifo.sv
      - src/sxt_perm_fork.sv
      - src/sxt_word_splitter.sv
      - src/sxt_regf_req.sv
      - src/sxt_ack_track.sv
      - src/sxt_final.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/sxt_final_tb.sv
